// ==== design/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ########################################
// datapath and data RAM geometry.
// ########################################

// width of a data word and of a register value.
`define DATA_W 32

// word address into the data RAM.
`define ADDR_W 8

`define RAM_WORDS 256

// ########################################
// exception flags carried down the pipe.
// ########################################

`define EXCEPT_LEN 4

`endif

// ==== design/pipe_pkg.sv ====
`include "core_defs.svh"

package pipe_pkg;

  // ########################################
  // per-item control fields from execute.
  // ########################################

  typedef logic [4:0] load_op_t;  // one-hot, zero when the item is no load.

  localparam int LD_B  = 0;  // byte, sign extended.
  localparam int LD_H  = 1;  // half, sign extended.
  localparam int LD_W  = 2;
  localparam int LD_BU = 3;  // byte, zero extended.
  localparam int LD_HU = 4;  // half, zero extended.

  typedef enum logic [1:0] {
    ST_NONE,
    ST_BYTE,
    ST_HALF,
    ST_WORD
  } store_op_t;

  typedef logic [2:0] mul_op_t;

  localparam int MUL_LO  = 0;  // low half of the product.
  localparam int MUL_HI  = 1;  // high half, signed operands.
  localparam int MUL_HIU = 2;  // high half, unsigned operands.

  typedef logic [`EXCEPT_LEN-1:0] except_t;

  // bits 2 and 3 are the exceptions that flush the pipe.
  function automatic logic ex_reported(except_t ex);
    return ex[2] | ex[3];
  endfunction

endpackage

// ==== design/mem_pkg.sv ====
package mem_pkg;

  // ########################################
  // data RAM side types.
  // ########################################

  // one RAM word, read as four byte lanes or as two halfword lanes.
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } load_word_u;

  typedef enum logic [1:0] {
    OWN_IDLE,
    OWN_STAGE,
    OWN_HOST
  } arb_owner_t;

endpackage

// ==== design/data_ram.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module data_ram (
  input  logic               clk,
  input  logic               ram_en,
  input  logic               ram_we,
  input  logic [`ADDR_W-1:0] ram_addr,
  input  logic [`DATA_W-1:0] ram_wdata,
  input  logic [3:0]         ram_wstrb,
  output logic [`DATA_W-1:0] ram_rdata
);

  logic [`DATA_W-1:0] mem [`RAM_WORDS];

  // a write returns the old word on the same cycle.
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_we && ram_wstrb[i]) begin
          mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
        end
      end
      ram_rdata <= mem[ram_addr];
    end
  end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_arbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               st_req,
  input  logic               st_we,
  input  logic [`ADDR_W-1:0] st_addr,
  input  logic [`DATA_W-1:0] st_wdata,
  input  logic [3:0]         st_wstrb,
  input  logic               host_req,
  input  logic               host_we,
  input  logic [`ADDR_W-1:0] host_addr,
  input  logic [`DATA_W-1:0] host_wdata,
  input  logic [3:0]         host_wstrb,
  input  logic [`DATA_W-1:0] ram_rdata,
  output logic               st_ack,
  output logic [`DATA_W-1:0] st_rdata,
  output logic               host_ack,
  output logic [`DATA_W-1:0] host_rdata,
  output logic               ram_en,
  output logic               ram_we,
  output logic [`ADDR_W-1:0] ram_addr,
  output logic [`DATA_W-1:0] ram_wdata,
  output logic [3:0]         ram_wstrb
);
  import mem_pkg::*;

  arb_owner_t owner;
  logic       access;     // the RAM cycle right after a grant.
  logic       last_host;  // the host was served last.
  logic       host_wins;

  assign host_wins = host_req && (!st_req || !last_host);

  // ########################################
  // grant, access, ack, release
  // ########################################

  always_ff @(posedge clk) begin
    if (reset) begin
      owner     <= OWN_IDLE;
      access    <= 1'b0;
      st_ack    <= 1'b0;
      host_ack  <= 1'b0;
      last_host <= 1'b0;
    end else begin
      access <= 1'b0;
      case (owner)
        OWN_IDLE: begin
          if (st_req || host_req) begin
            owner  <= host_wins ? OWN_HOST : OWN_STAGE;
            access <= 1'b1;
          end
        end
        OWN_STAGE: begin
          if (access) begin
            st_ack <= 1'b1;
          end else if (st_ack && !st_req) begin
            st_ack    <= 1'b0;
            owner     <= OWN_IDLE;
            last_host <= 1'b0;
          end
        end
        OWN_HOST: begin
          if (access) begin
            host_ack <= 1'b1;
          end else if (host_ack && !host_req) begin
            host_ack  <= 1'b0;
            owner     <= OWN_IDLE;
            last_host <= 1'b1;
          end
        end
        default: owner <= OWN_IDLE;
      endcase
    end
  end

  // the RAM output register holds its word until the next access.
  assign ram_en     = access;
  assign ram_we     = (owner == OWN_HOST) ? host_we    : st_we;
  assign ram_addr   = (owner == OWN_HOST) ? host_addr  : st_addr;
  assign ram_wdata  = (owner == OWN_HOST) ? host_wdata : st_wdata;
  assign ram_wstrb  = (owner == OWN_HOST) ? host_wstrb : st_wstrb;
  assign st_rdata   = ram_rdata;
  assign host_rdata = ram_rdata;

  a_one_ack : assert property (@(posedge clk) disable iff (reset)
    !(st_ack && host_ack))
    else $error("both requesters acked at once.");

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                es_valid,
  input  logic [`DATA_W-1:0]  es_pc,
  input  logic [`DATA_W-1:0]  es_alu_result,
  input  logic [`DATA_W-1:0]  es_store_data,
  input  pipe_pkg::load_op_t  es_load_op,
  input  pipe_pkg::store_op_t es_store_op,
  input  pipe_pkg::mul_op_t   es_mul_op,
  input  logic                es_res_from_mul,
  input  logic [4:0]          es_dest,
  input  logic                es_gr_we,
  input  pipe_pkg::except_t   es_except,
  input  logic [63:0]         mul_result,
  input  logic                ws_allowin,
  input  logic                wb_ex,
  input  logic                st_ack,
  input  logic [`DATA_W-1:0]  st_rdata,
  output logic                ms_allowin,
  output logic                ms2ws_valid,
  output logic [`DATA_W-1:0]  ms_pc,
  output logic                ms_gr_we,
  output logic [4:0]          ms_dest,
  output logic [`DATA_W-1:0]  ms_result,
  output pipe_pkg::except_t   ms_except,
  output logic                ms_ex,
  output logic                fwd_we,
  output logic [4:0]          fwd_dest,
  output logic [`DATA_W-1:0]  fwd_data,
  output logic                st_req,
  output logic                st_we,
  output logic [`ADDR_W-1:0]  st_addr,
  output logic [`DATA_W-1:0]  st_wdata,
  output logic [3:0]          st_wstrb
);
  import pipe_pkg::*;
  import mem_pkg::*;

  logic               ms_valid;
  logic               ms_ready_go;
  logic               accept;
  logic               es_mem;
  logic               start_hs;
  logic               hs_active;
  logic               ack_seen;
  logic               hs_done;
  logic [`DATA_W-1:0] mul_sel;
  logic [`DATA_W-1:0] exe_r;
  logic [`DATA_W-1:0] store_data_r;
  load_op_t           load_op_r;
  store_op_t          store_op_r;
  load_word_u         ld_word;
  logic [1:0]         offset;
  logic [7:0]         ld_byte;
  logic [15:0]        ld_half;
  logic [`DATA_W-1:0] ld_data;

  // ########################################
  // stage handshake
  // ########################################

  // a memory item is ready once ack has been seen high and then low.
  assign hs_done     = hs_active && ack_seen && !st_ack;
  assign ms_ready_go = !hs_active || hs_done;
  assign ms_allowin  = ms_ready_go && (!ms_valid || ws_allowin);
  assign ms2ws_valid = ms_valid && ms_ready_go;
  assign accept      = es_valid && ms_allowin;

  assign es_mem   = (|es_load_op) || (es_store_op != ST_NONE);
  assign start_hs = accept && !wb_ex && es_mem && !ex_reported(es_except);

  always_ff @(posedge clk) begin
    if (reset) begin
      ms_valid  <= 1'b0;
      hs_active <= 1'b0;
      ack_seen  <= 1'b0;
      st_req    <= 1'b0;
    end else begin
      if (wb_ex) begin
        ms_valid <= 1'b0;
      end else if (ms_allowin) begin
        ms_valid <= es_valid;
      end
      // a flushed handshake keeps running until the arbiter lets go.
      if (accept) begin
        hs_active <= start_hs;
        st_req    <= start_hs;
        ack_seen  <= 1'b0;
      end else if (hs_done) begin
        hs_active <= 1'b0;
        ack_seen  <= 1'b0;
      end else if (st_req && st_ack) begin
        st_req   <= 1'b0;
        ack_seen <= 1'b1;
      end
    end
  end

  assign mul_sel = ({`DATA_W{es_mul_op[MUL_LO]}} & mul_result[31:0])
                 | ({`DATA_W{es_mul_op[MUL_HI] | es_mul_op[MUL_HIU]}} & mul_result[63:32]);

  always_ff @(posedge clk) begin
    if (accept) begin
      ms_pc        <= es_pc;
      ms_gr_we     <= es_gr_we;
      ms_dest      <= es_dest;
      ms_except    <= es_except;
      load_op_r    <= es_load_op;
      store_op_r   <= es_store_op;
      store_data_r <= es_store_data;
      exe_r        <= es_res_from_mul ? mul_sel : es_alu_result;
    end
    if (st_req && st_ack) begin
      ld_word <= st_rdata;  // rdata is only valid while ack is high.
    end
  end

  // ########################################
  // RAM request fields
  // ########################################

  assign offset  = exe_r[1:0];
  assign st_addr = exe_r[`ADDR_W+1:2];
  assign st_we   = store_op_r != ST_NONE;

  always_comb begin
    st_wdata = store_data_r;
    st_wstrb = 4'b0000;
    case (store_op_r)
      ST_BYTE: begin
        st_wdata = {4{store_data_r[7:0]}};
        st_wstrb = 4'b0001 << offset;
      end
      ST_HALF: begin
        st_wdata = {2{store_data_r[15:0]}};
        st_wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      ST_WORD: st_wstrb = 4'b1111;
      default: st_wstrb = 4'b0000;
    endcase
  end

  // ########################################
  // load extraction and result select
  // ########################################

  assign ld_byte = ld_word.b[offset];
  assign ld_half = ld_word.h[offset[1]];

  always_comb begin
    ld_data = {`DATA_W{load_op_r[LD_W]}} & ld_word;
    if (load_op_r[LD_B]) begin
      ld_data = {{24{ld_byte[7]}}, ld_byte};
    end else if (load_op_r[LD_BU]) begin
      ld_data = {24'b0, ld_byte};
    end else if (load_op_r[LD_H]) begin
      ld_data = {{16{ld_half[15]}}, ld_half};
    end else if (load_op_r[LD_HU]) begin
      ld_data = {16'b0, ld_half};
    end
  end

  assign ms_result = (|load_op_r) ? ld_data : exe_r;
  assign ms_ex     = ms_valid && ex_reported(ms_except);
  assign fwd_we    = ms_valid && ms_gr_we;
  assign fwd_dest  = ms_dest;
  assign fwd_data  = ms_result;

  a_req_held : assert property (@(posedge clk) disable iff (reset)
    st_req && !st_ack |=> st_req)
    else $error("st_req dropped before ack.");

  a_load_onehot : assert property (@(posedge clk) disable iff (reset)
    accept |-> $onehot0(es_load_op))
    else $error("load op is not one-hot.");

endmodule

// ==== design/wb_stage.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module wb_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               ms2ws_valid,
  input  logic [`DATA_W-1:0] ms_pc,
  input  logic               ms_gr_we,
  input  logic [4:0]         ms_dest,
  input  logic [`DATA_W-1:0] ms_result,
  input  pipe_pkg::except_t  ms_except,
  output logic               ws_allowin,
  output logic               rf_we,
  output logic [4:0]         rf_waddr,
  output logic [`DATA_W-1:0] rf_wdata,
  output logic [`DATA_W-1:0] wb_pc,
  output logic               wb_ex
);
  import pipe_pkg::*;

  logic    ws_valid;
  logic    gr_we_r;
  except_t except_r;

  assign ws_allowin = 1'b1;  // writeback always finishes in one cycle.

  // the flush also drops whatever the memory stage hands over on this edge.
  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid <= 1'b0;
    end else if (wb_ex) begin
      ws_valid <= 1'b0;
    end else if (ws_allowin) begin
      ws_valid <= ms2ws_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ms2ws_valid && ws_allowin) begin
      wb_pc    <= ms_pc;
      gr_we_r  <= ms_gr_we;
      rf_waddr <= ms_dest;
      rf_wdata <= ms_result;
      except_r <= ms_except;
    end
  end

  assign wb_ex = ws_valid && ex_reported(except_r);
  assign rf_we = ws_valid && gr_we_r && !wb_ex && (rf_waddr != 5'd0);

  a_flush_drains : assert property (@(posedge clk) disable iff (reset)
    wb_ex |=> !ms2ws_valid)
    else $error("an item reached writeback right after a flush.");

endmodule

// ==== design/mem_wb_top.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_wb_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                es_valid,
  input  logic [`DATA_W-1:0]  es_pc,
  input  logic [`DATA_W-1:0]  es_alu_result,
  input  logic [`DATA_W-1:0]  es_store_data,
  input  pipe_pkg::load_op_t  es_load_op,
  input  pipe_pkg::store_op_t es_store_op,
  input  pipe_pkg::mul_op_t   es_mul_op,
  input  logic                es_res_from_mul,
  input  logic [4:0]          es_dest,
  input  logic                es_gr_we,
  input  pipe_pkg::except_t   es_except,
  input  logic [63:0]         mul_result,
  output logic                ms_allowin,
  output logic                fwd_we,
  output logic [4:0]          fwd_dest,
  output logic [`DATA_W-1:0]  fwd_data,
  output logic                ms_ex,
  input  logic                host_req,
  input  logic                host_we,
  input  logic [`ADDR_W-1:0]  host_addr,
  input  logic [`DATA_W-1:0]  host_wdata,
  input  logic [3:0]          host_wstrb,
  output logic                host_ack,
  output logic [`DATA_W-1:0]  host_rdata,
  output logic                rf_we,
  output logic [4:0]          rf_waddr,
  output logic [`DATA_W-1:0]  rf_wdata,
  output logic [`DATA_W-1:0]  wb_pc,
  output logic                wb_ex
);

  // ########################################
  // memory stage to writeback.
  // ########################################

  logic                ms2ws_valid;
  logic                ws_allowin;
  logic [`DATA_W-1:0]  ms_pc;
  logic                ms_gr_we;
  logic [4:0]          ms_dest;
  logic [`DATA_W-1:0]  ms_result;
  pipe_pkg::except_t   ms_except;

  // ########################################
  // stage port of the arbiter and the RAM.
  // ########################################

  logic                st_req;
  logic                st_we;
  logic [`ADDR_W-1:0]  st_addr;
  logic [`DATA_W-1:0]  st_wdata;
  logic [3:0]          st_wstrb;
  logic                st_ack;
  logic [`DATA_W-1:0]  st_rdata;
  logic                ram_en;
  logic                ram_we;
  logic [`ADDR_W-1:0]  ram_addr;
  logic [`DATA_W-1:0]  ram_wdata;
  logic [3:0]          ram_wstrb;
  logic [`DATA_W-1:0]  ram_rdata;

  // every port name matches the wire it connects to.
  mem_stage   mem_stage_i   (.*);
  mem_arbiter mem_arbiter_i (.*);
  data_ram    data_ram_i    (.*);
  wb_stage    wb_stage_i    (.*);

endmodule

// ==== test/tb_mem_wb.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_mem_wb;
  import pipe_pkg::*;

  localparam int CYC_HOST = 8;   // one four-phase host access.
  localparam int CYC_MEM  = 12;  // one load or store through the stage.
  localparam int TIMEOUT  = 4 * (16 + 64 * CYC_HOST + 4 * CYC_HOST + 52 * CYC_MEM
                                 + 48 * CYC_MEM + 32 * 4 + 12 * CYC_MEM
                                 + 40 * 2 * CYC_MEM + 40 * CYC_HOST);

  logic clk, reset, es_valid, es_res_from_mul, es_gr_we, ms_allowin, fwd_we, ms_ex;
  logic [`DATA_W-1:0] es_pc, es_alu_result, es_store_data, fwd_data, host_wdata, host_rdata;
  logic [`DATA_W-1:0] rf_wdata, wb_pc;
  load_op_t  es_load_op;
  store_op_t es_store_op;
  mul_op_t   es_mul_op;
  except_t   es_except;
  logic [63:0] mul_result;
  logic [4:0]  es_dest, fwd_dest, rf_waddr;
  logic host_req, host_we, host_ack, rf_we, wb_ex;
  logic [`ADDR_W-1:0] host_addr;
  logic [3:0] host_wstrb;

  logic [`DATA_W-1:0] ram_model [`RAM_WORDS];
  logic [4:0]  exp_dest [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_pc [$];
  logic        exp_ex [$];
  logic [4:0]  fwd_dest_q [$];
  logic [31:0] fwd_data_q [$];
  int errors = 0, tests = 0, cycles = 0;
  int host_reqs = 0, host_acks = 0, st_reqs = 0, st_acks = 0;
  logic host_ack_d = 1'b0, st_req_d = 1'b0, st_ack_d = 1'b0;

  mem_wb_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ########################################
  // reporting and reference model
  // ########################################

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error: %s (time %0t).", msg, $time);
  endtask

  function automatic logic [31:0] load_value(load_op_t op, logic [31:0] w, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[off*8 +: 8];
    h = w[off[1]*16 +: 16];
    if (op[LD_B]) return {{24{b[7]}}, b};
    if (op[LD_BU]) return {24'h0, b};
    if (op[LD_H]) return {{16{h[15]}}, h};
    if (op[LD_HU]) return {16'h0, h};
    return w;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, store_op_t op, logic [31:0] d,
                                        logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (op)
      ST_BYTE: w[off*8 +: 8] = d[7:0];
      ST_HALF: w[off[1]*16 +: 16] = d[15:0];
      ST_WORD: w = d;
      default: w = old;
    endcase
    return w;
  endfunction

  task automatic expect_write(input logic [4:0] dest, input logic [31:0] data);
    exp_ex.push_back(1'b0);
    exp_dest.push_back(dest);
    exp_data.push_back(data);
    exp_pc.push_back(es_pc + 32'd4);  // send_item gives the item the next pc.
  endtask

  // ########################################
  // stimulus tasks, entered after a rising edge
  // ########################################

  task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    host_wstrb <= 4'hf;
    host_reqs++;
    do @(negedge clk); while (!host_ack);
    rdata = host_rdata;  // valid only while ack is high.
    @(posedge clk);
    host_req <= 1'b0;
    do @(negedge clk); while (host_ack);
    @(posedge clk);
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] old_word;
    ram_model[addr] = data;
    host_access(1'b1, addr, data, old_word);
  endtask

  task automatic host_check(input logic [7:0] addr);
    logic [31:0] rd;
    host_access(1'b0, addr, 32'h0, rd);
    a_host_rd: assert (rd == ram_model[addr])
      else report_mismatch($sformatf("host read [%0d] = %h, expected %h", addr, rd,
                                     ram_model[addr]));
  endtask

  task automatic send_item(input logic [31:0] alu, input load_op_t ld, input store_op_t st,
                           input logic [31:0] sdata, input logic [4:0] dest,
                           input except_t ex, input mul_op_t mop);
    es_valid        <= 1'b1;
    es_pc           <= es_pc + 4;
    es_alu_result   <= alu;
    es_store_data   <= sdata;
    es_load_op      <= ld;
    es_store_op     <= st;
    es_dest         <= dest;
    es_gr_we        <= (st == ST_NONE);
    es_except       <= ex;
    es_mul_op       <= mop;
    es_res_from_mul <= |mop;
    do @(negedge clk); while (!ms_allowin);
    @(posedge clk);  // the item transfers on this edge.
  endtask

  task automatic load_check(input logic [7:0] addr, input logic [1:0] off, input load_op_t op);
    logic [4:0] dest;
    dest = 5'($urandom_range(31, 1));
    expect_write(dest, load_value(op, ram_model[addr], off));
    send_item({22'h0, addr, off}, op, ST_NONE, 32'h0, dest, '0, '0);
  endtask

  task automatic store_item(input logic [7:0] addr, input logic [1:0] off, input store_op_t op,
                            input logic [31:0] data);
    ram_model[addr] = merge(ram_model[addr], op, data, off);
    send_item({22'h0, addr, off}, '0, op, data, 5'd0, '0, '0);
  endtask

  task automatic end_test(input string name);
    es_valid <= 1'b0;
    do @(negedge clk); while (exp_ex.size() != 0 || !ms_allowin);
    repeat (3) @(negedge clk);
    @(posedge clk);
    a_host_acks: assert (host_acks == host_reqs)
      else report_problem($sformatf("%0d host requests got %0d acks", host_reqs, host_acks));
    a_st_acks: assert (st_acks == st_reqs)
      else report_problem($sformatf("%0d stage requests got %0d acks", st_reqs, st_acks));
    tests++;
    $display("test %0d (%s) finished, %0d errors so far", tests, name, errors);
  endtask

  // ########################################
  // monitor and checking assertions
  // ########################################

  always @(negedge clk) begin
    if (!reset) begin
      host_acks += int'(host_ack && !host_ack_d);
      st_reqs   += int'(dut_i.st_req && !st_req_d);
      st_acks   += int'(dut_i.st_ack && !st_ack_d);
      if (rf_we || wb_ex) begin
        if (exp_ex.size() == 0) begin
          report_problem("register write or flush with nothing outstanding");
        end else begin
          a_kind: assert (exp_ex[0] == wb_ex)
            else report_problem(wb_ex ? "flush on an item without exception"
                                      : "register write where a flush was due");
          a_pc: assert (wb_pc == exp_pc[0])
            else report_mismatch($sformatf("retired pc %h, expected %h", wb_pc, exp_pc[0]));
          if (rf_we) begin
            a_write: assert (rf_waddr == exp_dest[0] && rf_wdata == exp_data[0])
              else report_mismatch($sformatf("wrote x%0d = %h, expected x%0d = %h",
                                   rf_waddr, rf_wdata, exp_dest[0], exp_data[0]));
          end
          void'(exp_ex.pop_front());
          void'(exp_dest.pop_front());
          void'(exp_data.pop_front());
          void'(exp_pc.pop_front());
        end
      end
      if (rf_we && fwd_data_q.size() != 0) begin
        a_fwd: assert (fwd_dest_q[0] == rf_waddr && fwd_data_q[0] == rf_wdata)
          else report_mismatch($sformatf("forwarded x%0d = %h, written x%0d = %h",
                               fwd_dest_q[0], fwd_data_q[0], rf_waddr, rf_wdata));
        void'(fwd_dest_q.pop_front());
        void'(fwd_data_q.pop_front());
      end else if (rf_we) begin
        report_problem("register write that was never forwarded");
      end
      // the item leaves the memory stage on the next edge.
      if (fwd_we && dut_i.ms2ws_valid && !ms_ex && !wb_ex && fwd_dest != 5'd0) begin
        fwd_dest_q.push_back(fwd_dest);
        fwd_data_q.push_back(fwd_data);
      end
    end
    host_ack_d = host_ack;
    st_req_d   = dut_i.st_req;
    st_ack_d   = dut_i.st_ack;
  end

  a_ack_has_req: assert property (@(posedge clk) disable iff (reset)
    $rose(host_ack) |-> host_req) else report_problem("host ack rose without a request");
  a_ack_release: assert property (@(posedge clk) disable iff (reset)
    host_ack && !host_req |=> !host_ack) else report_problem("host ack held after release");
  a_no_ram_on_ex: assert property (@(posedge clk) disable iff (reset)
    ms_ex |-> !dut_i.st_req) else report_problem("RAM request for an excepting item");
  a_ex_from_ms: assert property (@(posedge clk) disable iff (reset)
    wb_ex |-> $past(ms_ex)) else report_problem("flush without the exception seen in memory");
  a_no_r0: assert property (@(posedge clk) disable iff (reset)
    rf_we |-> rf_waddr != 5'd0) else report_problem("register 0 was written");

  initial begin
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT);
    $display("** FAIL **");
    $finish;
  end

  // ########################################
  // test sequence
  // ########################################

  initial begin
    logic [7:0]  a;
    logic [7:0]  ha;
    logic [1:0]  off;
    store_op_t   st;
    logic [63:0] prod;
    logic [31:0] alu;
    mul_op_t     mop;
    logic [4:0]  dest;
    except_t     ex;
    void'($urandom(89727));
    reset = 1'b1;
    es_valid = 1'b0;
    es_pc = '0;
    es_alu_result = '0;
    es_store_data = '0;
    es_load_op = '0;
    es_store_op = ST_NONE;
    es_mul_op = '0;
    es_res_from_mul = 1'b0;
    es_dest = '0;
    es_gr_we = 1'b0;
    es_except = '0;
    mul_result = '0;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    host_wstrb = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    for (int i = 0; i < 32; i++) host_write(8'(i), $urandom());
    for (int i = 0; i < 32; i++) host_check(8'(i));
    end_test("host access");

    host_write(8'd40, 32'h80ff_7f01);  // sign bits set in alternate lanes.
    host_write(8'd41, 32'h7f80_01fe);
    host_write(8'd42, 32'hdead_beef);
    host_write(8'd43, 32'h1234_8765);
    for (int w = 40; w < 44; w++) begin
      for (int o = 0; o < 4; o++) begin
        load_check(8'(w), 2'(o), 5'(1 << LD_B));
        load_check(8'(w), 2'(o), 5'(1 << LD_BU));
        if (o % 2 == 0) begin
          load_check(8'(w), 2'(o), 5'(1 << LD_H));
          load_check(8'(w), 2'(o), 5'(1 << LD_HU));
        end
        if (o == 0) load_check(8'(w), 2'(o), 5'(1 << LD_W));
      end
    end
    end_test("load extraction");

    for (int i = 0; i < 24; i++) begin
      a = 8'($urandom_range(31, 0));
      st = store_op_t'($urandom_range(3, 1));
      off = (st == ST_BYTE) ? 2'($urandom) : (st == ST_HALF) ? {1'($urandom), 1'b0} : 2'b00;
      store_item(a, off, st, $urandom());
      load_check(a, 2'b00, 5'(1 << LD_W));
    end
    end_test("store merge");

    for (int i = 0; i < 32; i++) begin
      prod = {$urandom(), $urandom()};
      alu  = $urandom();
      mop  = (i % 2 == 0) ? 3'b000 : 3'(1 << $urandom_range(2, 0));
      dest = (i == 31) ? 5'd0 : 5'($urandom_range(31, 1));
      mul_result <= prod;
      if (dest != 5'd0) expect_write(dest, (mop == 0) ? alu : mop[0] ? prod[31:0] : prod[63:32]);
      send_item(alu, '0, ST_NONE, 32'h0, dest, except_t'($urandom_range(3, 0)), mop);
    end
    end_test("result selection");

    for (int i = 0; i < 4; i++) begin
      a  = 8'($urandom_range(31, 0));
      ex = (i % 2 == 1) ? 4'b1000 : 4'b0100;
      exp_ex.push_back(1'b1);
      exp_dest.push_back(5'd0);
      exp_data.push_back(32'h0);
      exp_pc.push_back(es_pc + 32'd4);
      send_item({22'h0, a, 2'b00}, (i < 2) ? 5'(1 << LD_W) : 5'b0,
                (i >= 2) ? ST_WORD : ST_NONE, $urandom(), 5'($urandom_range(31, 1)), ex, '0);
      // the item right behind is flushed and must never write.
      send_item({22'h0, a, 2'b00}, (i % 2 == 1) ? 5'(1 << LD_W) : 5'b0, ST_NONE, 32'h0,
                5'($urandom_range(31, 1)), '0, '0);
      es_valid <= 1'b0;
      @(posedge clk);
      load_check(a, 2'b00, 5'(1 << LD_W));
    end
    end_test("exception flush");

    fork
      begin
        for (int i = 0; i < 40; i++) begin
          a = 8'($urandom_range(31, 0));
          if ($urandom_range(1, 0) == 1) store_item(a, 2'b00, ST_WORD, $urandom());
          else load_check(a, 2'($urandom), 5'(1 << LD_BU));
        end
      end
      begin
        for (int i = 0; i < 20; i++) begin
          ha = 8'(64 + $urandom_range(31, 0));
          host_write(ha, $urandom());
          host_check(ha);
        end
      end
    join
    end_test("contention");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+design
design/pipe_pkg.sv
design/mem_pkg.sv
design/data_ram.sv
design/mem_arbiter.sv
design/mem_stage.sv
design/wb_stage.sv
design/mem_wb_top.sv
test/tb_mem_wb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
